// File: flist.f
hdl/csi_pkg.sv
hdl/csi_event_if.sv
hdl/frame_event_decoder.sv
hdl/raw10_packer.sv
hdl/packet_control.sv
hdl/csi2_packet_front.sv
verif/tb_csi2_packet_front.sv

// File: hdl/csi2_packet_front.sv
`timescale 1ns/100ps
`default_nettype none

module csi2_packet_front
    import csi_pkg::*;
(
    input  logic                   clock_camera_byte,
    input  logic                   reset_camera_byte_n,
    input  logic                   pixel_fv_i,
    input  logic                   pixel_lv_i,
    input  logic                   pixel_valid_i,
    input  logic [PIXEL_WIDTH-1:0] pixel_data_i,
    output logic [7:0]             byte_data_o,
    output logic                   byte_data_en_o,
    output csi_data_type_e         data_type_o,
    output logic [15:0]            word_count_o,
    output logic                   short_packet_en_o,
    output logic                   long_packet_en_o
);

    csi_event_if event_bus ();

    logic [7:0] packed_byte;
    logic       packed_byte_en;

    frame_event_decoder decoder (
        .clock_camera_byte   (clock_camera_byte),
        .reset_camera_byte_n (reset_camera_byte_n),
        .pixel_fv_i          (pixel_fv_i),
        .pixel_lv_i          (pixel_lv_i),
        .pixel_valid_i       (pixel_valid_i),
        .events_o            (event_bus.source)
    );

    raw10_packer packer (
        .clock_camera_byte   (clock_camera_byte),
        .reset_camera_byte_n (reset_camera_byte_n),
        .pixel_valid_i       (pixel_valid_i),
        .pixel_data_i        (pixel_data_i),
        .events_i            (event_bus.sink),
        .packed_byte_o       (packed_byte),
        .packed_byte_en_o    (packed_byte_en)
    );

    packet_control control (
        .clock_camera_byte   (clock_camera_byte),
        .reset_camera_byte_n (reset_camera_byte_n),
        .events_i            (event_bus.sink),
        .packed_byte_i       (packed_byte),
        .packed_byte_en_i    (packed_byte_en),
        .byte_data_o         (byte_data_o),
        .byte_data_en_o      (byte_data_en_o),
        .data_type_o         (data_type_o),
        .word_count_o        (word_count_o),
        .short_packet_en_o   (short_packet_en_o),
        .long_packet_en_o    (long_packet_en_o)
    );

endmodule

`default_nettype wire

// File: hdl/csi_event_if.sv
`timescale 1ns/100ps
`default_nettype none

interface csi_event_if;

    logic frame_start;  // fv rose
    logic frame_end;    // fv fell
    logic line_start;   // lv rose
    logic line_end;     // lv fell

    modport source (
        output frame_start,
        output frame_end,
        output line_start,
        output line_end
    );

    modport sink (
        input frame_start,
        input frame_end,
        input line_start,
        input line_end
    );

endinterface

`default_nettype wire

// File: hdl/csi_pkg.sv
`default_nettype none

package csi_pkg;

    localparam int PIXEL_WIDTH       = 10;
    localparam int LINE_PIXELS       = 16;  // must be a multiple of 4
    localparam int LINE_BYTES        = LINE_PIXELS * PIXEL_WIDTH / 8;  // long packet word count
    localparam int RAW10_GROUP_BYTES = 5;
    localparam int PAYLOAD_DELAY     = 3;  // payload trails the header strobes
    localparam int PIXEL_COUNT_WIDTH = $clog2(LINE_PIXELS + 1);

    // CSI-2 data type field
    typedef enum logic [5:0] {
        DT_FRAME_START = 6'h00,
        DT_FRAME_END   = 6'h01,
        DT_RAW10       = 6'h2B
    } csi_data_type_e;

    typedef enum logic [1:0] {
        PACK_IDLE,
        PACK_COLLECT,
        PACK_EMIT
    } packer_state_e;

endpackage

`default_nettype wire

// File: hdl/frame_event_decoder.sv
`timescale 1ns/100ps
`default_nettype none

module frame_event_decoder
    import csi_pkg::*;
(
    input  logic        clock_camera_byte,
    input  logic        reset_camera_byte_n,
    input  logic        pixel_fv_i,
    input  logic        pixel_lv_i,
    input  logic        pixel_valid_i,
    csi_event_if.source events_o
);

    logic                         fv_q;
    logic                         lv_q;
    logic                         line_rise;
    logic [PIXEL_COUNT_WIDTH-1:0] pixel_cnt;

    assign line_rise = pixel_lv_i & ~lv_q;

    // previous sample vs current input
    always_ff @(posedge clock_camera_byte or negedge reset_camera_byte_n) begin
        if (!reset_camera_byte_n) begin
            fv_q                 <= 1'b0;
            lv_q                 <= 1'b0;
            events_o.frame_start <= 1'b0;
            events_o.frame_end   <= 1'b0;
            events_o.line_start  <= 1'b0;
            events_o.line_end    <= 1'b0;
        end else begin
            fv_q                 <= pixel_fv_i;
            lv_q                 <= pixel_lv_i;
            events_o.frame_start <= pixel_fv_i & ~fv_q;
            events_o.frame_end   <= ~pixel_fv_i & fv_q;
            events_o.line_start  <= line_rise;
            events_o.line_end    <= ~pixel_lv_i & lv_q;
        end
    end

    // valid pixels seen in the current line
    always_ff @(posedge clock_camera_byte or negedge reset_camera_byte_n) begin
        if (!reset_camera_byte_n) begin
            pixel_cnt <= '0;
        end else if (line_rise) begin
            pixel_cnt <= PIXEL_COUNT_WIDTH'(pixel_valid_i);  // first pixel may ride the edge
        end else if (pixel_valid_i) begin
            pixel_cnt <= pixel_cnt + PIXEL_COUNT_WIDTH'(1);
        end
    end

    // count is final by the time the line_end pulse is out
    line_length_check: assert property (
        @(posedge clock_camera_byte) disable iff (!reset_camera_byte_n)
        events_o.line_end |-> pixel_cnt == PIXEL_COUNT_WIDTH'(LINE_PIXELS)
    );

    pixel_in_line_check: assert property (
        @(posedge clock_camera_byte) disable iff (!reset_camera_byte_n)
        pixel_valid_i |-> pixel_lv_i
    );

    line_in_frame_check: assert property (
        @(posedge clock_camera_byte) disable iff (!reset_camera_byte_n)
        line_rise |-> pixel_fv_i
    );

endmodule

`default_nettype wire

// File: hdl/packet_control.sv
`timescale 1ns/100ps
`default_nettype none

module packet_control
    import csi_pkg::*;
(
    input  logic           clock_camera_byte,
    input  logic           reset_camera_byte_n,
    csi_event_if.sink      events_i,
    input  logic [7:0]     packed_byte_i,
    input  logic           packed_byte_en_i,
    output logic [7:0]     byte_data_o,
    output logic           byte_data_en_o,
    output csi_data_type_e data_type_o,
    output logic [15:0]    word_count_o,
    output logic           short_packet_en_o,
    output logic           long_packet_en_o
);

    logic [7:0]               byte_pipe [PAYLOAD_DELAY];
    logic [PAYLOAD_DELAY-1:0] en_pipe;
    logic                     line_open;

    always_ff @(posedge clock_camera_byte or negedge reset_camera_byte_n) begin
        if (!reset_camera_byte_n) begin
            short_packet_en_o <= 1'b0;
            long_packet_en_o  <= 1'b0;
        end else begin
            short_packet_en_o <= events_i.frame_start | events_i.frame_end;
            long_packet_en_o  <= events_i.line_start;
        end
    end

    // header fields hold until the next event
    always_ff @(posedge clock_camera_byte or negedge reset_camera_byte_n) begin
        if (!reset_camera_byte_n) begin
            data_type_o  <= DT_FRAME_START;
            word_count_o <= 16'd0;
        end else if (events_i.frame_start) begin
            data_type_o  <= DT_FRAME_START;
            word_count_o <= 16'd0;
        end else if (events_i.frame_end) begin
            data_type_o  <= DT_FRAME_END;
            word_count_o <= 16'd0;
        end else if (events_i.line_start) begin
            data_type_o  <= DT_RAW10;
            word_count_o <= 16'(LINE_BYTES);
        end
    end

    always_ff @(posedge clock_camera_byte or negedge reset_camera_byte_n) begin
        if (!reset_camera_byte_n) begin
            line_open <= 1'b0;
        end else if (events_i.line_start) begin
            line_open <= 1'b1;
        end else if (events_i.line_end) begin
            line_open <= 1'b0;
        end
    end

    always_ff @(posedge clock_camera_byte or negedge reset_camera_byte_n) begin
        if (!reset_camera_byte_n) begin
            en_pipe <= '0;
        end else begin
            en_pipe <= {en_pipe[PAYLOAD_DELAY-2:0], packed_byte_en_i};
        end
    end

    always_ff @(posedge clock_camera_byte) begin
        byte_pipe[0] <= packed_byte_i;
        for (int i = 1; i < PAYLOAD_DELAY; i++) begin
            byte_pipe[i] <= byte_pipe[i-1];
        end
    end

    assign byte_data_o    = byte_pipe[PAYLOAD_DELAY-1];
    assign byte_data_en_o = en_pipe[PAYLOAD_DELAY-1];

    // only one header per cycle
    start_collision_check: assert property (
        @(posedge clock_camera_byte) disable iff (!reset_camera_byte_n)
        !(events_i.frame_start && events_i.line_start)
    );

    frame_end_check: assert property (
        @(posedge clock_camera_byte) disable iff (!reset_camera_byte_n)
        events_i.frame_end |-> !line_open
    );

endmodule

`default_nettype wire

// File: hdl/raw10_packer.sv
`timescale 1ns/100ps
`default_nettype none

module raw10_packer
    import csi_pkg::*;
(
    input  logic                   clock_camera_byte,
    input  logic                   reset_camera_byte_n,
    input  logic                   pixel_valid_i,
    input  logic [PIXEL_WIDTH-1:0] pixel_data_i,
    csi_event_if.sink              events_i,
    output logic [7:0]             packed_byte_o,
    output logic                   packed_byte_en_o
);

    packer_state_e                      state_q;
    packer_state_e                      state_d;
    logic [1:0]                         slot_cnt;
    logic [1:0]                         slot_d;
    logic                               group_done;
    logic [PIXEL_WIDTH-1:0]             group_q [3];  // fourth pixel comes straight from the input
    logic [7:0]                         group_bytes [RAW10_GROUP_BYTES];
    logic [(RAW10_GROUP_BYTES-1)*8-1:0] emit_sr;
    logic [2:0]                         emit_cnt;     // bytes left in emit_sr

    assign group_done = pixel_valid_i && (slot_cnt == 2'd3);

    // RAW10 group with the low bits of all four pixels in the last byte
    assign group_bytes[0] = group_q[0][PIXEL_WIDTH-1:2];
    assign group_bytes[1] = group_q[1][PIXEL_WIDTH-1:2];
    assign group_bytes[2] = group_q[2][PIXEL_WIDTH-1:2];
    assign group_bytes[3] = pixel_data_i[PIXEL_WIDTH-1:2];
    assign group_bytes[4] = {pixel_data_i[1:0], group_q[2][1:0],
                             group_q[1][1:0], group_q[0][1:0]};

    always_comb begin
        slot_d = slot_cnt;
        if (events_i.line_end) begin
            slot_d = 2'd0;  // drop partial group
        end else if (pixel_valid_i) begin
            slot_d = slot_cnt + 2'd1;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            PACK_IDLE: begin
                if (slot_d != 2'd0)
                    state_d = PACK_COLLECT;
            end
            PACK_COLLECT: begin
                if (group_done)
                    state_d = PACK_EMIT;
                else if (slot_d == 2'd0)
                    state_d = PACK_IDLE;
            end
            PACK_EMIT: begin
                if (!group_done && emit_cnt == 3'd1)  // last byte leaves this cycle
                    state_d = (slot_d != 2'd0) ? PACK_COLLECT : PACK_IDLE;
            end
            default: begin
                state_d = PACK_IDLE;
            end
        endcase
    end

    always_ff @(posedge clock_camera_byte or negedge reset_camera_byte_n) begin
        if (!reset_camera_byte_n) begin
            state_q          <= PACK_IDLE;
            slot_cnt         <= 2'd0;
            emit_cnt         <= 3'd0;
            packed_byte_en_o <= 1'b0;
        end else begin
            state_q          <= state_d;
            slot_cnt         <= slot_d;
            packed_byte_en_o <= group_done || (state_q == PACK_EMIT);
            if (group_done) begin
                emit_cnt <= 3'(RAW10_GROUP_BYTES - 1);
            end else if (state_q == PACK_EMIT) begin
                emit_cnt <= emit_cnt - 3'd1;
            end
        end
    end

    always_ff @(posedge clock_camera_byte) begin
        if (pixel_valid_i && slot_cnt != 2'd3) begin
            group_q[slot_cnt] <= pixel_data_i;
        end
        if (group_done) begin
            packed_byte_o <= group_bytes[0];  // first byte goes out at once
            emit_sr       <= {group_bytes[4], group_bytes[3], group_bytes[2], group_bytes[1]};
        end else if (state_q == PACK_EMIT) begin
            packed_byte_o <= emit_sr[7:0];
            emit_sr       <= emit_sr >> 8;
        end
    end

    // only the byte on the output may still be pending when a new group lands
    pacing_check: assert property (
        @(posedge clock_camera_byte) disable iff (!reset_camera_byte_n)
        group_done |-> emit_cnt == 3'd0
    );

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the CSI-2 front end testbench with Verilator and runs it.

set -u

cd "$(dirname "$0")" || exit 1

TOP=tb_csi2_packet_front
BUILD_DIR=obj_dir

if ! command -v verilator >/dev/null 2>&1; then
    echo "verilator not found in PATH"
    exit 1
fi

verilator --binary --timing --assert -j 0 \
    --top-module "$TOP" -Mdir "$BUILD_DIR" -f flist.f
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

output=$("./$BUILD_DIR/V$TOP" 2>&1)
status=$?
echo "$output"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "Test completed successfully"; then
    exit 0
fi
exit 1

// File: verif/tb_csi2_packet_front.sv
`timescale 1ns/100ps
`default_nettype none

module tb_csi2_packet_front
    import csi_pkg::*;
();

    localparam int          CLOCK_PERIOD    = 10;
    localparam logic [31:0] SEED            = 32'h87fe_310d;
    localparam int          LINES_PER_FRAME = 3;
    localparam int          LINE_GAP        = 8;  // keeps fv and lv edges apart
    localparam int          MAX_GAP         = 5;
    localparam int          NUM_FRAMES      = 3;
    localparam int          LINE_CYCLES     = LINE_PIXELS * (MAX_GAP + 2) + LINE_GAP + 2;
    localparam int          FRAME_CYCLES    = LINES_PER_FRAME * LINE_CYCLES + 3 * LINE_GAP + 20;
    localparam int          RUN_CYCLES      = 10 + NUM_FRAMES * FRAME_CYCLES + 50;

    logic                   clock_camera_byte;
    logic                   reset_camera_byte_n;
    logic                   pixel_fv_i;
    logic                   pixel_lv_i;
    logic                   pixel_valid_i;
    logic [PIXEL_WIDTH-1:0] pixel_data_i;
    logic [7:0]             byte_data_o;
    logic                   byte_data_en_o;
    csi_data_type_e         data_type_o;
    logic [15:0]            word_count_o;
    logic                   short_packet_en_o;
    logic                   long_packet_en_o;

    logic                   fs_mark;   // set with the level change
    logic                   fe_mark;
    logic                   ls_mark;
    logic                   grp_mark;  // set with the fourth pixel of a group
    logic [1:0]             fs_pipe;
    logic [1:0]             fe_pipe;
    logic [1:0]             ls_pipe;
    logic [7:0]             grp_pipe;
    csi_data_type_e         exp_type;
    logic [15:0]            exp_wc;
    logic [7:0]             exp_q [$];
    logic [7:0]             exp_head;
    logic                   payload_open;
    int                     line_byte_cnt;
    logic [3:0]             recent;    // valid history for pacing
    logic [31:0]            rnd;
    int                     error_count;
    int                     tests_run;
    int                     tests_failed;
    int                     errors_before;

    csi2_packet_front UUT (
        .clock_camera_byte   (clock_camera_byte),
        .reset_camera_byte_n (reset_camera_byte_n),
        .pixel_fv_i          (pixel_fv_i),
        .pixel_lv_i          (pixel_lv_i),
        .pixel_valid_i       (pixel_valid_i),
        .pixel_data_i        (pixel_data_i),
        .byte_data_o         (byte_data_o),
        .byte_data_en_o      (byte_data_en_o),
        .data_type_o         (data_type_o),
        .word_count_o        (word_count_o),
        .short_packet_en_o   (short_packet_en_o),
        .long_packet_en_o    (long_packet_en_o)
    );

    always #(CLOCK_PERIOD / 2) clock_camera_byte = ~clock_camera_byte;

    function automatic logic [31:0] xorshift32(input logic [31:0] state);
        logic [31:0] x;
        x = state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // expected strobes two cycles after the sampled edge
    always @(posedge clock_camera_byte) begin
        fs_pipe  <= {fs_pipe[0], fs_mark};
        fe_pipe  <= {fe_pipe[0], fe_mark};
        ls_pipe  <= {ls_pipe[0], ls_mark};
        grp_pipe <= {grp_pipe[6:0], grp_mark};
        if (fs_pipe[0]) begin
            exp_type <= DT_FRAME_START;
            exp_wc   <= 16'd0;
        end else if (fe_pipe[0]) begin
            exp_type <= DT_FRAME_END;
            exp_wc   <= 16'd0;
        end else if (ls_pipe[0]) begin
            exp_type <= DT_RAW10;
            exp_wc   <= 16'(LINE_BYTES);
        end
    end

    always @(posedge clock_camera_byte) begin
        if (reset_camera_byte_n && byte_data_en_o) begin
            assert (exp_q.size() != 0) else begin
                error_count++;
                $display("a payload byte came out with no expected byte left");
            end
            if (exp_q.size() != 0)
                void'(exp_q.pop_front());
        end
        exp_head <= (exp_q.size() != 0) ? exp_q[0] : 8'h00;
        if (long_packet_en_o || short_packet_en_o) begin
            if (payload_open) begin
                assert (line_byte_cnt == LINE_BYTES) else begin
                    error_count++;
                    $display("** Error line byte count: got %h expected %h",
                             line_byte_cnt, LINE_BYTES);
                end
            end
            payload_open  <= long_packet_en_o;
            line_byte_cnt <= 0;
        end else if (byte_data_en_o) begin
            line_byte_cnt <= line_byte_cnt + 1;
        end
    end

    reset_outputs_check: assert property (
        @(posedge clock_camera_byte)
        !reset_camera_byte_n |-> (!byte_data_en_o && !short_packet_en_o && !long_packet_en_o
                                  && data_type_o == DT_FRAME_START && word_count_o == 16'd0)
    ) else begin
        error_count++;
        $display("** Error reset: byte_data_en_o=%h short_packet_en_o=%h long_packet_en_o=%h",
                 $sampled(byte_data_en_o), $sampled(short_packet_en_o),
                 $sampled(long_packet_en_o));
        $display("** Error reset: data_type_o=%h word_count_o=%h",
                 $sampled(data_type_o), $sampled(word_count_o));
    end

    short_strobe_check: assert property (
        @(posedge clock_camera_byte) disable iff (!reset_camera_byte_n)
        short_packet_en_o == (fs_pipe[1] | fe_pipe[1])
    ) else begin
        error_count++;
        $display("** Error short_packet_en_o: got %h expected %h",
                 $sampled(short_packet_en_o), $sampled(fs_pipe[1] | fe_pipe[1]));
    end

    long_strobe_check: assert property (
        @(posedge clock_camera_byte) disable iff (!reset_camera_byte_n)
        long_packet_en_o == ls_pipe[1]
    ) else begin
        error_count++;
        $display("** Error long_packet_en_o: got %h expected %h",
                 $sampled(long_packet_en_o), $sampled(ls_pipe[1]));
    end

    data_type_check: assert property (
        @(posedge clock_camera_byte) disable iff (!reset_camera_byte_n)
        data_type_o == exp_type
    ) else begin
        error_count++;
        $display("** Error data_type_o: got %h expected %h",
                 $sampled(data_type_o), $sampled(exp_type));
    end

    word_count_check: assert property (
        @(posedge clock_camera_byte) disable iff (!reset_camera_byte_n)
        word_count_o == exp_wc
    ) else begin
        error_count++;
        $display("** Error word_count_o: got %h expected %h",
                 $sampled(word_count_o), $sampled(exp_wc));
    end

    // bytes on k+4 .. k+8 after the completing pixel
    byte_enable_check: assert property (
        @(posedge clock_camera_byte) disable iff (!reset_camera_byte_n)
        byte_data_en_o == (|grp_pipe[7:3])
    ) else begin
        error_count++;
        $display("** Error byte_data_en_o: got %h expected %h",
                 $sampled(byte_data_en_o), $sampled(|grp_pipe[7:3]));
    end

    byte_value_check: assert property (
        @(posedge clock_camera_byte) disable iff (!reset_camera_byte_n)
        byte_data_en_o |-> byte_data_o == exp_head
    ) else begin
        error_count++;
        $display("** Error byte_data_o: got %h expected %h",
                 $sampled(byte_data_o), $sampled(exp_head));
    end

    payload_window_check: assert property (
        @(posedge clock_camera_byte) disable iff (!reset_camera_byte_n)
        byte_data_en_o |-> payload_open
    ) else begin
        error_count++;
        $display("a payload byte came out before its line header or after frame end");
    end

    task automatic drive_cycle(input logic valid, input logic [PIXEL_WIDTH-1:0] data);
        @(negedge clock_camera_byte);
        fs_mark       = 1'b0;
        fe_mark       = 1'b0;
        ls_mark       = 1'b0;
        grp_mark      = 1'b0;
        pixel_valid_i = valid;
        pixel_data_i  = data;
        recent        = {recent[2:0], valid};
    endtask

    task automatic send_line(input int mode);
        int                     sent;
        int                     gap;
        logic [1:0]             slot;
        logic [PIXEL_WIDTH-1:0] group [4];
        sent = 0;
        slot = 2'd0;
        drive_cycle(1'b0, '0);
        pixel_lv_i = 1'b1;
        ls_mark    = 1'b1;
        while (sent < LINE_PIXELS) begin
            if (recent == 4'b1111) begin
                drive_cycle(1'b0, '0);  // four in five limit
            end else begin
                rnd = xorshift32(rnd);
                drive_cycle(1'b1, rnd[PIXEL_WIDTH-1:0]);
                group[slot] = rnd[PIXEL_WIDTH-1:0];
                if (slot == 2'd3) begin
                    grp_mark = 1'b1;
                    exp_q.push_back(group[0][PIXEL_WIDTH-1:2]);
                    exp_q.push_back(group[1][PIXEL_WIDTH-1:2]);
                    exp_q.push_back(group[2][PIXEL_WIDTH-1:2]);
                    exp_q.push_back(group[3][PIXEL_WIDTH-1:2]);
                    exp_q.push_back({group[3][1:0], group[2][1:0],
                                     group[1][1:0], group[0][1:0]});
                end
                slot = slot + 2'd1;
                sent++;
                gap = (mode == 0) ? 0 : (mode == 1) ? int'(rnd[10]) : 2 + int'(rnd[11:10]);
                repeat (gap) drive_cycle(1'b0, '0);
            end
        end
        drive_cycle(1'b0, '0);
        pixel_lv_i = 1'b0;
        repeat (LINE_GAP) drive_cycle(1'b0, '0);
    endtask

    task automatic send_frame(input int mode);
        drive_cycle(1'b0, '0);
        pixel_fv_i = 1'b1;
        fs_mark    = 1'b1;
        repeat (LINE_GAP) drive_cycle(1'b0, '0);
        repeat (LINES_PER_FRAME) send_line(mode);
        drive_cycle(1'b0, '0);
        pixel_fv_i = 1'b0;
        fe_mark    = 1'b1;
        repeat (LINE_GAP) drive_cycle(1'b0, '0);
    endtask

    task automatic report_test(input string name);
        tests_run++;
        if (error_count != errors_before)
            tests_failed++;
        $display("test %0d %s: %0d errors", tests_run, name, error_count - errors_before);
        errors_before = error_count;
    endtask

    initial begin
        #(RUN_CYCLES * CLOCK_PERIOD);
        $display("watchdog expired after %0d cycles, the run did not finish", RUN_CYCLES);
        $display("Test failed");
        $finish;
    end

    initial begin
        clock_camera_byte   = 1'b0;
        reset_camera_byte_n = 1'b0;
        pixel_fv_i          = 1'b0;
        pixel_lv_i          = 1'b0;
        pixel_valid_i       = 1'b0;
        pixel_data_i        = '0;
        {fs_mark, fe_mark, ls_mark, grp_mark} = 4'b0000;
        {fs_pipe, fe_pipe, ls_pipe} = 6'b0;
        grp_pipe      = 8'h00;
        exp_type      = DT_FRAME_START;
        exp_wc        = 16'd0;
        exp_head      = 8'h00;
        payload_open  = 1'b0;
        line_byte_cnt = 0;
        recent        = 4'b0000;
        rnd           = SEED;
        error_count   = 0;
        tests_run     = 0;
        tests_failed  = 0;
        errors_before = 0;
        repeat (3) @(posedge clock_camera_byte);
        @(negedge clock_camera_byte);
        reset_camera_byte_n = 1'b1;
        repeat (2) drive_cycle(1'b0, '0);
        report_test("reset values");
        send_frame(0);
        report_test("frame at full pixel rate");
        send_frame(1);
        report_test("frame with random gaps");
        send_frame(2);
        report_test("sparse frame");
        assert (exp_q.size() == 0) else begin
            error_count++;
            $display("%0d expected payload bytes never came out", exp_q.size());
        end
        $display("tests run %0d, tests failed %0d, errors %0d",
                 tests_run, tests_failed, error_count);
        if (error_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
